/* rtl/r5p_pkg.sv */
package r5p_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // register and address width
  localparam int unsigned xlen = 32;

  // register value, address, bus data
  typedef logic [xlen-1:0] xw_t;
  // register index
  typedef logic [4:0] reg_adr_t;
  // raw instruction word
  typedef logic [31:0] ins_t;

  // reset pc
  localparam xw_t pc0 = '0;

  ////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////

  // bits [6:0] of the instruction word
  localparam logic [6:0] opc_op    = 7'b0110011;
  localparam logic [6:0] opc_imm   = 7'b0010011;
  localparam logic [6:0] opc_lui   = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_jal   = 7'b1101111;
  localparam logic [6:0] opc_jalr  = 7'b1100111;
  localparam logic [6:0] opc_br    = 7'b1100011;
  localparam logic [6:0] opc_ld    = 7'b0000011;
  localparam logic [6:0] opc_st    = 7'b0100011;

  ////////////////////////////////////////
  // control enums
  ////////////////////////////////////////

  // next pc source
  typedef enum logic [1:0] {pc_inc, pc_jal, pc_jalr, pc_br} pc_sel_t;

  // alu operand 1, zero for lui
  typedef enum logic [1:0] {a1_rs1, a1_pc, a1_zero} a1_sel_t;

  // alu operand 2
  typedef enum logic {a2_rs2, a2_imm} a2_sel_t;

  // alu function
  typedef enum logic [3:0] {
    op_add, op_sub, op_and, op_or, op_xor,
    op_slt, op_sltu, op_sll, op_srl, op_sra
  } alu_op_t;

  // branch condition
  typedef enum logic [2:0] {br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu} br_op_t;

  // write-back source, none means no register write
  typedef enum logic [1:0] {wb_none, wb_alu, wb_ld, wb_pc4} wb_sel_t;

endpackage

/* rtl/r5p_fetch.sv */
`timescale 1ns/10ps

module r5p_fetch (
  input  logic             clk,
  input  logic             rst,
  input  logic             if_ack,
  input  logic             stall,
  input  r5p_pkg::pc_sel_t pc_sel,
  input  logic             taken,
  input  r5p_pkg::xw_t     tgt,
  output r5p_pkg::xw_t     pc,
  output logic             if_req,
  output r5p_pkg::xw_t     if_adr
);

  import r5p_pkg::*;

  xw_t pc_inc4;
  xw_t pcn;

  // sequential successor
  assign pc_inc4 = pc + xw_t'(4);

  // next pc, held while no word is present or a memory access waits
  always_comb begin
    if (!if_ack || stall) begin
      pcn = pc;
    end else begin
      case (pc_sel)
        pc_jal:  pcn = tgt;
        // jalr clears bit 0 of the target
        pc_jalr: pcn = {tgt[xlen-1:1], 1'b0};
        pc_br:   pcn = taken ? tgt : pc_inc4;
        default: pcn = pc_inc4;
      endcase
    end
  end

  // request goes high on the first edge after reset and stays
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      if_req <= 1'b0;
      pc     <= pc0;
    end else begin
      if_req <= 1'b1;
      pc     <= pcn;
    end
  end

  // memory samples next pc, word returns with the next ack
  assign if_adr = pcn;

endmodule

/* rtl/r5p_decode.sv */
`timescale 1ns/10ps

module r5p_decode (
  input  r5p_pkg::ins_t     ins,
  output r5p_pkg::reg_adr_t rs1_adr,
  output r5p_pkg::reg_adr_t rs2_adr,
  output r5p_pkg::reg_adr_t rd_adr,
  output r5p_pkg::xw_t      imm,
  output r5p_pkg::pc_sel_t  pc_sel,
  output r5p_pkg::a1_sel_t  a1_sel,
  output r5p_pkg::a2_sel_t  a2_sel,
  output r5p_pkg::alu_op_t  alu_op,
  output r5p_pkg::br_op_t   br_op,
  output r5p_pkg::wb_sel_t  wb_sel,
  output logic              ld,
  output logic              st
);

  import r5p_pkg::*;

  logic [6:0] opc;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xw_t        imm_i;
  xw_t        imm_s;
  xw_t        imm_b;
  xw_t        imm_u;
  xw_t        imm_j;
  alu_op_t    alu_f3;

  ////////////////////////////////////////
  // fields
  ////////////////////////////////////////

  assign opc     = ins[6:0];
  assign rd_adr  = ins[11:7];
  assign funct3  = ins[14:12];
  assign rs1_adr = ins[19:15];
  assign rs2_adr = ins[24:20];
  assign funct7  = ins[31:25];

  // immediates, all sign extended from bit 31
  assign imm_i = {{20{ins[31]}}, ins[31:20]};
  assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  assign imm_u = {ins[31:12], 12'h000};
  assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

  ////////////////////////////////////////
  // alu and branch functions
  ////////////////////////////////////////

  // funct3 map shared by register and immediate forms
  always_comb begin
    case (funct3)
      // no subi, bit 30 belongs to the immediate there
      3'b000:  alu_f3 = (opc == opc_op && funct7[5]) ? op_sub : op_add;
      3'b001:  alu_f3 = op_sll;
      3'b010:  alu_f3 = op_slt;
      3'b011:  alu_f3 = op_sltu;
      3'b100:  alu_f3 = op_xor;
      3'b101:  alu_f3 = funct7[5] ? op_sra : op_srl;
      3'b110:  alu_f3 = op_or;
      default: alu_f3 = op_and;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b001:  br_op = br_ne;
      3'b100:  br_op = br_lt;
      3'b101:  br_op = br_ge;
      3'b110:  br_op = br_ltu;
      3'b111:  br_op = br_geu;
      default: br_op = br_eq;
    endcase
  end

  ////////////////////////////////////////
  // main decode
  ////////////////////////////////////////

  always_comb begin
    // defaults give a no-op
    pc_sel = pc_inc;
    a1_sel = a1_rs1;
    a2_sel = a2_rs2;
    alu_op = op_add;
    wb_sel = wb_none;
    imm    = '0;
    ld     = 1'b0;
    st     = 1'b0;
    case (opc)
      opc_op: begin
        alu_op = alu_f3;
        wb_sel = wb_alu;
      end
      opc_imm: begin
        a2_sel = a2_imm;
        imm    = imm_i;
        alu_op = alu_f3;
        wb_sel = wb_alu;
      end
      opc_lui: begin
        a1_sel = a1_zero;
        a2_sel = a2_imm;
        imm    = imm_u;
        wb_sel = wb_alu;
      end
      opc_auipc: begin
        a1_sel = a1_pc;
        a2_sel = a2_imm;
        imm    = imm_u;
        wb_sel = wb_alu;
      end
      // a1_pc also picks pc as target adder base
      opc_jal: begin
        pc_sel = pc_jal;
        a1_sel = a1_pc;
        imm    = imm_j;
        wb_sel = wb_pc4;
      end
      opc_jalr: begin
        pc_sel = pc_jalr;
        imm    = imm_i;
        wb_sel = wb_pc4;
      end
      opc_br: begin
        pc_sel = pc_br;
        a1_sel = a1_pc;
        imm    = imm_b;
      end
      opc_ld: begin
        imm    = imm_i;
        ld     = 1'b1;
        wb_sel = wb_ld;
      end
      opc_st: begin
        imm    = imm_s;
        st     = 1'b1;
      end
      default: begin
        // unknown opcode, defaults stand
      end
    endcase
  end

endmodule

/* rtl/r5p_gpr.sv */
`timescale 1ns/10ps

module r5p_gpr (
  input  logic              clk,
  input  logic              rst,
  input  r5p_pkg::reg_adr_t rs1_adr,
  input  r5p_pkg::reg_adr_t rs2_adr,
  input  r5p_pkg::reg_adr_t rd_adr,
  input  logic              wen,
  input  r5p_pkg::xw_t      rd_dat,
  output r5p_pkg::xw_t      rs1,
  output r5p_pkg::xw_t      rs2
);

  import r5p_pkg::*;

  // register array, entry 0 never written
  xw_t regs [32];

  // one write per edge, x0 ignored
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd_adr != '0) begin
      regs[rd_adr] <= rd_dat;
    end
  end

  // asynchronous reads
  assign rs1 = (rs1_adr == '0) ? '0 : regs[rs1_adr];
  assign rs2 = (rs2_adr == '0) ? '0 : regs[rs2_adr];

endmodule

/* rtl/r5p_execute.sv */
`timescale 1ns/10ps

module r5p_execute (
  input  r5p_pkg::xw_t     pc,
  input  r5p_pkg::xw_t     rs1,
  input  r5p_pkg::xw_t     rs2,
  input  r5p_pkg::xw_t     imm,
  input  r5p_pkg::a1_sel_t a1_sel,
  input  r5p_pkg::a2_sel_t a2_sel,
  input  r5p_pkg::alu_op_t alu_op,
  input  r5p_pkg::br_op_t  br_op,
  output r5p_pkg::xw_t     res,
  output r5p_pkg::xw_t     sum,
  output logic             taken
);

  import r5p_pkg::*;

  xw_t        op1;
  xw_t        op2;
  logic [4:0] shamt;

  ////////////////////////////////////////
  // operands
  ////////////////////////////////////////

  always_comb begin
    case (a1_sel)
      a1_pc:   op1 = pc;
      a1_zero: op1 = '0;
      default: op1 = rs1;
    endcase
  end

  assign op2 = (a2_sel == a2_imm) ? imm : rs2;

  // low 5 bits only
  assign shamt = op2[4:0];

  ////////////////////////////////////////
  // alu
  ////////////////////////////////////////

  always_comb begin
    case (alu_op)
      op_sub:  res = op1 - op2;
      op_and:  res = op1 & op2;
      op_or:   res = op1 | op2;
      op_xor:  res = op1 ^ op2;
      op_slt:  res = xw_t'($signed(op1) < $signed(op2));
      op_sltu: res = xw_t'(op1 < op2);
      op_sll:  res = op1 << shamt;
      op_srl:  res = op1 >> shamt;
      op_sra:  res = xw_t'($signed(op1) >>> shamt);
      default: res = op1 + op2;
    endcase
  end

  // target and memory address
  // pc base for jal and branches, rs1 for jalr and memory
  assign sum = ((a1_sel == a1_pc) ? pc : rs1) + imm;

  // branch comparator, fetch looks at it only for branches
  always_comb begin
    case (br_op)
      br_ne:   taken = (rs1 != rs2);
      br_lt:   taken = ($signed(rs1) < $signed(rs2));
      br_ge:   taken = ($signed(rs1) >= $signed(rs2));
      br_ltu:  taken = (rs1 < rs2);
      br_geu:  taken = (rs1 >= rs2);
      default: taken = (rs1 == rs2);
    endcase
  end

endmodule

/* rtl/r5p_lsu.sv */
`timescale 1ns/10ps

module r5p_lsu (
  input  logic             if_ack,
  input  logic             ld,
  input  logic             st,
  input  r5p_pkg::wb_sel_t wb_sel,
  input  r5p_pkg::xw_t     sum,
  input  r5p_pkg::xw_t     rs2,
  input  r5p_pkg::xw_t     res,
  input  r5p_pkg::xw_t     pc,
  input  r5p_pkg::xw_t     ls_rdt,
  input  logic             ls_ack,
  output logic             ls_req,
  output logic             ls_wen,
  output r5p_pkg::xw_t     ls_adr,
  output logic [3:0]       ls_sel,
  output r5p_pkg::xw_t     ls_wdt,
  output logic             stall,
  output logic             wen,
  output r5p_pkg::xw_t     rd_dat
);

  import r5p_pkg::*;

  // memory instruction currently present
  logic mem;

  assign mem = if_ack & (ld | st);

  // data bus, word access only
  assign ls_req = mem;
  assign ls_wen = if_ack & st;
  assign ls_adr = sum;
  assign ls_sel = 4'b1111;
  assign ls_wdt = rs2;

  // hold until the data memory answers
  assign stall = mem & ~ls_ack;

  // write only in the completing cycle
  assign wen = if_ack & ~stall & (wb_sel != wb_none);

  always_comb begin
    case (wb_sel)
      wb_ld:   rd_dat = ls_rdt;
      wb_pc4:  rd_dat = pc + xw_t'(4);
      default: rd_dat = res;
    endcase
  end

endmodule

/* rtl/r5p_core.sv */
`timescale 1ns/10ps

module r5p_core (
  input  logic          clk,
  input  logic          rst,
  // program bus
  output logic          if_req,
  output r5p_pkg::xw_t  if_adr,
  input  r5p_pkg::ins_t if_rdt,
  input  logic          if_ack,
  // data bus
  output logic          ls_req,
  output logic          ls_wen,
  output r5p_pkg::xw_t  ls_adr,
  output logic [3:0]    ls_sel,
  output r5p_pkg::xw_t  ls_wdt,
  input  r5p_pkg::xw_t  ls_rdt,
  input  logic          ls_ack
);

  import r5p_pkg::*;

  ////////////////////////////////////////
  // local signals
  ////////////////////////////////////////

  // fetch
  xw_t      pc;
  logic     stall;
  // decode
  reg_adr_t rs1_adr;
  reg_adr_t rs2_adr;
  reg_adr_t rd_adr;
  xw_t      imm;
  pc_sel_t  pc_sel;
  a1_sel_t  a1_sel;
  a2_sel_t  a2_sel;
  alu_op_t  alu_op;
  br_op_t   br_op;
  wb_sel_t  wb_sel;
  logic     ld;
  logic     st;
  // register file
  xw_t      rs1;
  xw_t      rs2;
  logic     wen;
  xw_t      rd_dat;
  // execute
  xw_t      res;
  xw_t      sum;
  logic     taken;

  ////////////////////////////////////////
  // stages
  ////////////////////////////////////////

  r5p_fetch u_fetch (
    .clk    (clk),
    .rst    (rst),
    .if_ack (if_ack),
    .stall  (stall),
    .pc_sel (pc_sel),
    .taken  (taken),
    .tgt    (sum),
    .pc     (pc),
    .if_req (if_req),
    .if_adr (if_adr)
  );

  // instruction word straight from the bus
  r5p_decode u_decode (
    .ins     (if_rdt),
    .rs1_adr (rs1_adr),
    .rs2_adr (rs2_adr),
    .rd_adr  (rd_adr),
    .imm     (imm),
    .pc_sel  (pc_sel),
    .a1_sel  (a1_sel),
    .a2_sel  (a2_sel),
    .alu_op  (alu_op),
    .br_op   (br_op),
    .wb_sel  (wb_sel),
    .ld      (ld),
    .st      (st)
  );

  r5p_gpr u_gpr (
    .clk     (clk),
    .rst     (rst),
    .rs1_adr (rs1_adr),
    .rs2_adr (rs2_adr),
    .rd_adr  (rd_adr),
    .wen     (wen),
    .rd_dat  (rd_dat),
    .rs1     (rs1),
    .rs2     (rs2)
  );

  r5p_execute u_execute (
    .pc     (pc),
    .rs1    (rs1),
    .rs2    (rs2),
    .imm    (imm),
    .a1_sel (a1_sel),
    .a2_sel (a2_sel),
    .alu_op (alu_op),
    .br_op  (br_op),
    .res    (res),
    .sum    (sum),
    .taken  (taken)
  );

  // memory access and write-back
  r5p_lsu u_lsu (
    .if_ack (if_ack),
    .ld     (ld),
    .st     (st),
    .wb_sel (wb_sel),
    .sum    (sum),
    .rs2    (rs2),
    .res    (res),
    .pc     (pc),
    .ls_rdt (ls_rdt),
    .ls_ack (ls_ack),
    .ls_req (ls_req),
    .ls_wen (ls_wen),
    .ls_adr (ls_adr),
    .ls_sel (ls_sel),
    .ls_wdt (ls_wdt),
    .stall  (stall),
    .wen    (wen),
    .rd_dat (rd_dat)
  );

endmodule

/* testbench/r5p_core_tb.sv */
`timescale 1ns/10ps

module r5p_core_tb;

  import r5p_pkg::*;

  localparam int unsigned lfsr_taps = 32'h8020_0003;

  logic        clk;
  logic        rst;
  logic        if_req;
  logic [31:0] if_adr;
  logic [31:0] if_rdt;
  logic        if_ack;
  logic        ls_req;
  logic        ls_wen;
  logic [31:0] ls_adr;
  logic [3:0]  ls_sel;
  logic [31:0] ls_wdt;
  logic [31:0] ls_rdt;
  logic        ls_ack;

  // program and data memories, model state
  logic [31:0] pmem [256];
  logic [31:0] dmem [256];
  logic [31:0] mregs [32];
  logic [31:0] mdmem [256];
  logic [31:0] mpc;
  logic [31:0] fetch_adr;
  logic [31:0] halt_adr;
  logic [31:0] lfsr;
  logic [1:0]  dly;
  logic        halted;
  int          pa;
  int          errors;
  int          checks;
  int          tests;
  int          mem_writes;
  int          model_stores;

  r5p_core u_r5p_core (
    .clk    (clk),
    .rst    (rst),
    .if_req (if_req),
    .if_adr (if_adr),
    .if_rdt (if_rdt),
    .if_ack (if_ack),
    .ls_req (ls_req),
    .ls_wen (ls_wen),
    .ls_adr (ls_adr),
    .ls_sel (ls_sel),
    .ls_wdt (ls_wdt),
    .ls_rdt (ls_rdt),
    .ls_ack (ls_ack)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // galois lfsr, shifts right, taps folded in on a one
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? lfsr_taps : 32'h0);
  endfunction

  // two lfsr bits give a wait of 0 to 3 cycles
  task automatic draw_delay(output logic [1:0] d);
    int i;
    for (i = 0; i < 2; i++) begin
      d[i] = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                        input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc_op};
  endfunction

  function automatic logic [31:0] enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                        input int rd, input logic [6:0] opc);
    return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
    logic [11:0] v;
    v = 12'(imm);
    return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], opc_st};
  endfunction

  function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                        input logic [2:0] f3);
    logic [12:0] v;
    v = 13'(imm);
    return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], opc_br};
  endfunction

  function automatic logic [31:0] enc_j(input int imm, input int rd);
    logic [20:0] v;
    v = 21'(imm);
    return {v[20], v[10:1], v[11], v[19:12], 5'(rd), opc_jal};
  endfunction

  task automatic put(input logic [31:0] w);
    pmem[pa] = w;
    pa++;
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // one instruction on the model, returns the next pc
  function automatic logic [31:0] ref_step(input logic [31:0] ins, output logic st_en,
                                           output logic [31:0] st_adr,
                                           output logic [31:0] st_dat);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ii;
    logic [31:0] npc;
    logic [31:0] val;
    logic        wr;
    logic        tk;
    a      = mregs[ins[19:15]];
    b      = mregs[ins[24:20]];
    ii     = {{20{ins[31]}}, ins[31:20]};
    npc    = mpc + 32'd4;
    val    = '0;
    wr     = 1'b1;
    st_en  = 1'b0;
    st_adr = '0;
    st_dat = '0;
    case (ins[6:0])
      opc_op:    val = alu_ref(ins[14:12], ins[30], a, b);
      opc_imm:   val = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, ii);
      opc_lui:   val = {ins[31:12], 12'h0};
      opc_auipc: val = mpc + {ins[31:12], 12'h0};
      opc_jal: begin
        val = mpc + 32'd4;
        npc = mpc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      opc_jalr: begin
        val = mpc + 32'd4;
        npc = (a + ii) & ~32'd1;
      end
      opc_br: begin
        wr = 1'b0;
        case (ins[14:12])
          3'd0:    tk = a == b;
          3'd1:    tk = a != b;
          3'd4:    tk = $signed(a) < $signed(b);
          3'd5:    tk = $signed(a) >= $signed(b);
          3'd6:    tk = a < b;
          default: tk = a >= b;
        endcase
        if (tk) begin
          npc = mpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      opc_ld:    val = mdmem[8'((a + ii) >> 2)];
      opc_st: begin
        wr     = 1'b0;
        st_en  = 1'b1;
        st_adr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        st_dat = b;
        mdmem[st_adr[9:2]] = b;
      end
      default:   wr = 1'b0;
    endcase
    if (wr && ins[11:7] != 5'd0) begin
      mregs[ins[11:7]] = val;
    end
    return npc;
  endfunction

  ////////////////////////////////////////
  // memories
  ////////////////////////////////////////

  assign ls_ack = !rst && ls_req && dly == 2'd0;
  assign ls_rdt = dmem[ls_adr[9:2]];

  always @(posedge clk) begin
    logic        r;
    logic        f_req;
    logic [31:0] f_adr;
    logic        d_req;
    logic        d_ack;
    logic        d_wen;
    logic [31:0] d_adr;
    logic [31:0] d_wdt;
    r     = rst;
    f_req = if_req;
    f_adr = if_adr;
    d_req = ls_req;
    d_ack = ls_ack;
    d_wen = ls_wen;
    d_adr = ls_adr;
    d_wdt = ls_wdt;
    #1;
    if (!r && d_req && d_ack && d_wen) begin
      dmem[d_adr[9:2]] = d_wdt;
      mem_writes++;
    end
    if (!r && d_req) begin
      if (d_ack) draw_delay(dly);
      else dly = dly - 2'd1;
    end
    // word for the sampled address arrives with ack
    if_ack = f_req;
    if (f_req) begin
      fetch_adr = f_adr;
      if_rdt    = pmem[f_adr[9:2]];
    end
  end

  ////////////////////////////////////////
  // compare against the model
  ////////////////////////////////////////

  always @(posedge clk) begin
    logic [31:0] npc;
    logic        st_en;
    logic [31:0] st_adr;
    logic [31:0] st_dat;
    if (!rst && if_ack) begin
      // word access, all four lanes
      if (ls_req) begin
        check("byte select", {28'b0, ls_sel}, 32'h0000_000f);
      end
      if (ls_req && !ls_ack) begin
        // waiting memory access, same word again
        check("pc held during wait", if_adr, fetch_adr);
      end else begin
        check("fetch address", fetch_adr, mpc);
        npc = ref_step(if_rdt, st_en, st_adr, st_dat);
        check("store enable", {31'b0, ls_wen}, {31'b0, st_en});
        if (st_en) begin
          model_stores++;
          check("store address", ls_adr, st_adr);
          check("store data", ls_wdt, st_dat);
        end
        if (fetch_adr == halt_adr) halted = 1'b1;
        mpc = npc;
      end
    end
  end

  ////////////////////////////////////////
  // test sequencing
  ////////////////////////////////////////

  task automatic run_test(input string name);
    int n;
    int e0;
    e0 = errors;
    @(posedge clk);
    #1 rst = 1'b1;
    // data bus is quiet from this edge on
    @(posedge clk);
    halt_adr = 32'(pa * 4);
    put(enc_j(0, 0));
    for (n = 0; n < 256; n++) begin
      dmem[n]  = 32'h9e37_79b1 * 32'(n + 1);
      mdmem[n] = dmem[n];
    end
    for (n = 0; n < 32; n++) mregs[n] = '0;
    mpc          = pc0;
    halted       = 1'b0;
    mem_writes   = 0;
    model_stores = 0;
    repeat (7) @(posedge clk);
    check("if_req in reset", {31'b0, if_req}, 32'd0);
    check("ls_req in reset", {31'b0, ls_req}, 32'd0);
    check("ls_wen in reset", {31'b0, ls_wen}, 32'd0);
    #1 rst = 1'b0;
    n = 0;
    while (!halted && n < 4000) begin
      @(posedge clk);
      n++;
    end
    if (!halted) begin
      errors++;
      $display("timeout: test %s never reached its final jump", name);
    end else begin
      check("memory writes", 32'(mem_writes), 32'(model_stores));
    end
    tests++;
    $display("test %s: %0d errors", name, errors - e0);
  endtask

  task automatic clear_program();
    int n;
    for (n = 0; n < 256; n++) pmem[n] = '0;
    pa = 0;
  endtask

  initial begin
    int f;
    int k;
    int off;
    rst = 1'b1;
    if_rdt = '0;
    if_ack = 1'b0;
    dly = '0;
    lfsr = 32'd94586;
    fetch_adr = '0;
    halt_adr = '1;
    errors = 0;
    checks = 0;
    tests = 0;

    // alu, register and immediate forms
    clear_program();
    put(enc_i(-5, 0, 3'd0, 1, opc_imm));
    put(enc_i(7, 0, 3'd0, 2, opc_imm));
    put({20'h80000, 5'd3, opc_lui});
    put(enc_i(291, 3, 3'd0, 3, opc_imm));
    put(32'h0000_0fff);
    off = 0;
    for (f = 0; f < 8; f++) begin
      for (k = 0; k < 6; k++) begin
        if (k < 3 || f == 0 || f == 5) begin
          put(enc_r(k < 3 ? 7'h00 : 7'h20, k % 3 == 0 ? 2 : (k % 3 == 1 ? 1 : 2),
                    k % 3 == 0 ? 1 : (k % 3 == 1 ? 2 : 3), 3'(f), 10));
          put(enc_s(off, 10, 0));
          off += 4;
        end
      end
      for (k = 1; k < 4; k += 2) begin
        put(enc_i(f == 1 ? 4 : (f == 5 ? 4 : -3), k, 3'(f), 10, opc_imm));
        put(enc_s(off, 10, 0));
        off += 4;
      end
    end
    put(enc_i(32'h404, 3, 3'd5, 10, opc_imm));
    put(enc_s(off, 10, 0));
    run_test("alu");

    // upper immediates
    clear_program();
    put({20'habcde, 5'd5, opc_lui});
    put(enc_s(0, 5, 0));
    put({20'h12345, 5'd6, opc_auipc});
    put(enc_s(4, 6, 0));
    put(enc_i(-1, 5, 3'd0, 7, opc_imm));
    put(enc_s(8, 7, 0));
    run_test("lui_auipc");

    // six branches taken and not taken, plus a backward loop
    clear_program();
    put(enc_i(-5, 0, 3'd0, 1, opc_imm));
    put(enc_i(7, 0, 3'd0, 2, opc_imm));
    put(enc_i(-5, 0, 3'd0, 3, opc_imm));
    for (f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        put(enc_b(8, 2, 1, 3'(f)));
        put(enc_i(1, 11, 3'd0, 11, opc_imm));
        put(enc_b(8, 1, 2, 3'(f)));
        put(enc_i(1, 11, 3'd0, 11, opc_imm));
        put(enc_b(8, 3, 1, 3'(f)));
        put(enc_i(1, 11, 3'd0, 11, opc_imm));
      end
    end
    put(enc_s(0, 11, 0));
    put(enc_i(3, 0, 3'd0, 12, opc_imm));
    put(enc_i(-1, 12, 3'd0, 12, opc_imm));
    put(enc_b(-4, 0, 12, 3'd1));
    put(enc_s(4, 12, 0));
    run_test("branch");

    // jal, jalr with odd offset, writes to x0
    clear_program();
    put(enc_j(8, 1));
    put(enc_i(1, 0, 3'd0, 5, opc_imm));
    put(enc_s(0, 1, 0));
    put(enc_i((pa + 3) * 4, 0, 3'd0, 2, opc_imm));
    put(enc_i(1, 2, 3'd0, 3, opc_jalr));
    put(enc_i(2, 0, 3'd0, 5, opc_imm));
    put(enc_s(4, 3, 0));
    put(enc_s(8, 5, 0));
    put(enc_j(8, 0));
    put(enc_i(1, 0, 3'd0, 6, opc_imm));
    put(enc_i(5, 0, 3'd0, 0, opc_imm));
    put(enc_s(12, 0, 0));
    put(enc_s(16, 6, 0));
    run_test("jump");

    // loads and stores under random ack delay
    clear_program();
    for (k = 0; k < 8; k++) begin
      put(enc_i(64 + 4 * k, 0, 3'd2, 1, opc_ld));
      put(enc_i(k, 1, 3'd0, 1, opc_imm));
      put(enc_s(128 + 4 * k, 1, 0));
      put(enc_i(128 + 4 * k, 0, 3'd2, 2, opc_ld));
      put(enc_s(192 + 4 * k, 2, 0));
    end
    put(enc_i(256, 0, 3'd0, 4, opc_imm));
    put(enc_i(-4, 4, 3'd2, 5, opc_ld));
    put(enc_s(-8, 5, 4));
    run_test("load_store");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* project.f */
rtl/r5p_pkg.sv
rtl/r5p_fetch.sv
rtl/r5p_decode.sv
rtl/r5p_gpr.sv
rtl/r5p_execute.sv
rtl/r5p_lsu.sv
rtl/r5p_core.sv
testbench/r5p_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= r5p_core_tb
FLIST     ?= project.f
SRCS      := $(shell grep -v '^+' $(FLIST))
BIN       := obj_dir/V$(TOP)
LOG       := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then exit 1; fi
	@grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
